// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_pipeline
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
design/rv_pkg.sv
design/rv_stage_reg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_hazard_unit.sv
design/rv_execute.sv
design/rv_lsu.sv
design/rv_pipeline_top.sv
verification/tb_mem_model.sv
verification/tb_rv_pipeline.sv

// File: design/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  wire rv_pkg::word_t instr,
  output rv_pkg::ctrl_t      ctrl,
  output rv_pkg::word_t      imm
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  rv_pkg::imm_kind_t imm_kind;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_t op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  op = rv_pkg::alu_sll;
      3'b010:  op = rv_pkg::alu_slt;
      3'b011:  op = rv_pkg::alu_sltu;
      3'b100:  op = rv_pkg::alu_xor;
      3'b101:  op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  op = rv_pkg::alu_or;
      default: op = rv_pkg::alu_and;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl = '0;
    ctrl.funct3 = funct3;
    imm_kind = rv_pkg::imm_i;
    case (opcode)
      rv_pkg::op_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = rv_pkg::alu_pass_b;
        ctrl.alu_src_b = rv_pkg::src_b_imm;
        imm_kind       = rv_pkg::imm_u;
      end
      rv_pkg::op_auipc: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src_a = rv_pkg::src_a_pc;
        ctrl.alu_src_b = rv_pkg::src_b_imm;
        imm_kind       = rv_pkg::imm_u;
      end
      rv_pkg::op_jal: begin
        ctrl.reg_write   = 1'b1;
        ctrl.result_src  = rv_pkg::res_pc_plus_4;
        ctrl.branch_kind = rv_pkg::br_jal;
        imm_kind         = rv_pkg::imm_j;
      end
      rv_pkg::op_jalr: begin
        ctrl.reg_write   = 1'b1;
        ctrl.result_src  = rv_pkg::res_pc_plus_4;
        ctrl.branch_kind = rv_pkg::br_jalr;
      end
      rv_pkg::op_branch: begin
        ctrl.branch_kind = rv_pkg::br_cond;
        ctrl.alu_op      = rv_pkg::alu_sub;
        imm_kind         = rv_pkg::imm_b;
      end
      rv_pkg::op_load: begin
        ctrl.reg_write    = 1'b1;
        ctrl.mem_read     = 1'b1;
        ctrl.mem_size     = rv_pkg::mem_size_t'(funct3[1:0]);
        ctrl.mem_unsigned = funct3[2];
        ctrl.result_src   = rv_pkg::res_mem;
        ctrl.alu_src_b    = rv_pkg::src_b_imm;
      end
      rv_pkg::op_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.mem_size  = rv_pkg::mem_size_t'(funct3[1:0]);
        ctrl.alu_src_b = rv_pkg::src_b_imm;
        imm_kind       = rv_pkg::imm_s;
      end
      rv_pkg::op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src_b = rv_pkg::src_b_imm;
        // Only SRAI uses funct7 here, ADDI has no subtract form
        ctrl.alu_op    = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
      end
      rv_pkg::op_reg: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_sel(funct3, funct7[5]);
      end
      default: begin
        ctrl.funct3 = 3'b000;
      end
    endcase
  end

  always_comb begin
    case (imm_kind)
      rv_pkg::imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      rv_pkg::imm_b: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
      rv_pkg::imm_u: imm = {instr[31:12], 12'b0};
      rv_pkg::imm_j: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
      default:       imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire rv_pkg::id_ex_t   ex,
  input  wire rv_pkg::fwd_sel_t fwd_a,
  input  wire rv_pkg::fwd_sel_t fwd_b,
  input  wire rv_pkg::word_t    result_m,
  input  wire rv_pkg::word_t    result_w,
  output rv_pkg::word_t         alu_result,
  output rv_pkg::word_t         store_data,
  output logic                  take_branch,
  output rv_pkg::word_t         branch_target
);

  rv_pkg::word_t rs1_val;
  rv_pkg::word_t rs2_val;
  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  logic          cond_true;

  always_comb begin
    case (fwd_a)
      rv_pkg::fwd_mem: rs1_val = result_m;
      rv_pkg::fwd_wb:  rs1_val = result_w;
      default:         rs1_val = ex.rd1;
    endcase
    case (fwd_b)
      rv_pkg::fwd_mem: rs2_val = result_m;
      rv_pkg::fwd_wb:  rs2_val = result_w;
      default:         rs2_val = ex.rd2;
    endcase
  end

  assign op_a = (ex.ctrl.alu_src_a == rv_pkg::src_a_pc) ? ex.pc : rs1_val;
  assign op_b = (ex.ctrl.alu_src_b == rv_pkg::src_b_imm) ? ex.imm : rs2_val;
  assign store_data = rs2_val;

  always_comb begin
    case (ex.ctrl.alu_op)
      rv_pkg::alu_sub:    alu_result = op_a - op_b;
      rv_pkg::alu_sll:    alu_result = op_a << op_b[4:0];
      rv_pkg::alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu:   alu_result = {31'b0, op_a < op_b};
      rv_pkg::alu_xor:    alu_result = op_a ^ op_b;
      rv_pkg::alu_srl:    alu_result = op_a >> op_b[4:0];
      rv_pkg::alu_sra:    alu_result = $signed(op_a) >>> op_b[4:0];
      rv_pkg::alu_or:     alu_result = op_a | op_b;
      rv_pkg::alu_and:    alu_result = op_a & op_b;
      rv_pkg::alu_pass_b: alu_result = op_b;
      default:            alu_result = op_a + op_b;
    endcase
  end

  // Branch compare works on the forwarded register values
  always_comb begin
    case (ex.ctrl.funct3)
      3'b000:  cond_true = rs1_val == rs2_val;
      3'b001:  cond_true = rs1_val != rs2_val;
      3'b100:  cond_true = $signed(rs1_val) < $signed(rs2_val);
      3'b101:  cond_true = $signed(rs1_val) >= $signed(rs2_val);
      3'b110:  cond_true = rs1_val < rs2_val;
      3'b111:  cond_true = rs1_val >= rs2_val;
      default: cond_true = 1'b0;
    endcase
  end

  always_comb begin
    case (ex.ctrl.branch_kind)
      rv_pkg::br_cond: take_branch = cond_true;
      rv_pkg::br_jal:  take_branch = 1'b1;
      rv_pkg::br_jalr: take_branch = 1'b1;
      default:         take_branch = 1'b0;
    endcase
  end

  assign branch_target = (ex.ctrl.branch_kind == rv_pkg::br_jalr)
                         ? ((rs1_val + ex.imm) & ~32'd1)
                         : (ex.pc + ex.imm);

endmodule

`default_nettype wire

// File: design/rv_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_hazard_unit (
  input  wire rv_pkg::reg_addr_t rs1_e,
  input  wire rv_pkg::reg_addr_t rs2_e,
  input  wire rv_pkg::reg_addr_t rd_e,
  input  wire rv_pkg::reg_addr_t rs1_d,
  input  wire rv_pkg::reg_addr_t rs2_d,
  input  wire rv_pkg::reg_addr_t rd_m,
  input  wire rv_pkg::reg_addr_t rd_w,
  input  wire                    mem_read_e,
  input  wire                    reg_write_m,
  input  wire                    reg_write_w,
  input  wire                    take_branch,
  output rv_pkg::fwd_sel_t       fwd_a,
  output rv_pkg::fwd_sel_t       fwd_b,
  output logic                   stall_fd,
  output logic                   flush_d,
  output logic                   flush_e
);

  logic load_use;

  function automatic rv_pkg::fwd_sel_t pick_fwd(input rv_pkg::reg_addr_t rs);
    rv_pkg::fwd_sel_t sel;
    sel = rv_pkg::fwd_none;
    if (rs != 5'd0 && reg_write_m && rs == rd_m) begin
      sel = rv_pkg::fwd_mem;
    end else if (rs != 5'd0 && reg_write_w && rs == rd_w) begin
      sel = rv_pkg::fwd_wb;
    end
    return sel;
  endfunction

  assign fwd_a = pick_fwd(rs1_e);
  assign fwd_b = pick_fwd(rs2_e);

  // Load result is only ready once the load reaches memory
  assign load_use = mem_read_e && rd_e != 5'd0 && (rd_e == rs1_d || rd_e == rs2_d);

  assign stall_fd = load_use;
  assign flush_d  = take_branch;
  assign flush_e  = take_branch || load_use;

endmodule

`default_nettype wire

// File: design/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
  input  wire rv_pkg::ex_mem_t mem,
  output rv_pkg::word_t        data_wdata,
  output logic [3:0]           data_wenable,
  input  wire rv_pkg::word_t   data_rdata,
  output rv_pkg::word_t        load_data
);

  logic [1:0]    offset;
  logic [3:0]    lanes;
  rv_pkg::word_t shifted;

  assign offset = mem.alu_result[1:0];

  // Replicate so the right lane holds the data whatever the offset
  always_comb begin
    case (mem.ctrl.mem_size)
      rv_pkg::size_byte: begin
        data_wdata = {4{mem.store_data[7:0]}};
        lanes      = 4'b0001 << offset;
      end
      rv_pkg::size_half: begin
        data_wdata = {2{mem.store_data[15:0]}};
        lanes      = 4'b0011 << {offset[1], 1'b0};
      end
      default: begin
        data_wdata = mem.store_data;
        lanes      = 4'b1111;
      end
    endcase
  end

  assign data_wenable = mem.ctrl.mem_write ? lanes : 4'b0000;

  assign shifted = data_rdata >> {offset, 3'b000};

  always_comb begin
    case (mem.ctrl.mem_size)
      rv_pkg::size_byte:
        load_data = {{24{!mem.ctrl.mem_unsigned && shifted[7]}}, shifted[7:0]};
      rv_pkg::size_half:
        load_data = {{16{!mem.ctrl.mem_unsigned && shifted[15]}}, shifted[15:0]};
      default:
        load_data = data_rdata;
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_pipeline_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline_top (
  input  wire                clk,
  input  wire                rst_n,
  output rv_pkg::word_t      instr_addr,
  input  wire rv_pkg::word_t instr_data,
  output rv_pkg::word_t      data_addr,
  output rv_pkg::word_t      data_wdata,
  output logic [3:0]         data_wenable,
  input  wire rv_pkg::word_t data_rdata
);

  localparam rv_pkg::if_id_t if_id_bubble = '{instr: rv_pkg::nop_instr, pc: '0};

  rv_pkg::word_t    pc;
  rv_pkg::if_id_t   if_id_d, if_id_q;
  rv_pkg::id_ex_t   id_ex_d, id_ex_q;
  rv_pkg::ex_mem_t  ex_mem_d, ex_mem_q;
  rv_pkg::mem_wb_t  mem_wb_d, mem_wb_q;

  rv_pkg::ctrl_t    ctrl_d;
  rv_pkg::word_t    imm_d;
  rv_pkg::word_t    rd1_d;
  rv_pkg::word_t    rd2_d;

  rv_pkg::fwd_sel_t fwd_a;
  rv_pkg::fwd_sel_t fwd_b;
  logic             stall_fd;
  logic             flush_d;
  logic             flush_e;

  rv_pkg::word_t    alu_result_e;
  rv_pkg::word_t    store_data_e;
  logic             take_branch;
  rv_pkg::word_t    branch_target;

  rv_pkg::word_t    load_data_m;
  rv_pkg::word_t    result_m;

  // Fetch
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (take_branch) begin
      pc <= branch_target;
    end else if (!stall_fd) begin
      pc <= pc + 32'd4;
    end
  end

  assign instr_addr = pc;
  assign if_id_d    = '{instr: instr_data, pc: pc};

  rv_stage_reg #(
    .payload_t(rv_pkg::if_id_t),
    .bubble   (if_id_bubble)
  ) u_if_id (
    .clk  (clk),
    .rst_n(rst_n),
    .stall(stall_fd),
    .flush(flush_d),
    .d    (if_id_d),
    .q    (if_id_q)
  );

  // Decode
  rv_decoder u_decoder (
    .instr(if_id_q.instr),
    .ctrl (ctrl_d),
    .imm  (imm_d)
  );

  rv_regfile u_regfile (
    .clk  (clk),
    .rst_n(rst_n),
    .ra1  (if_id_q.instr[19:15]),
    .ra2  (if_id_q.instr[24:20]),
    .rd1  (rd1_d),
    .rd2  (rd2_d),
    .we   (mem_wb_q.reg_write),
    .wa   (mem_wb_q.rd),
    .wd   (mem_wb_q.result)
  );

  always_comb begin
    id_ex_d.ctrl = ctrl_d;
    id_ex_d.pc   = if_id_q.pc;
    id_ex_d.rd1  = rd1_d;
    id_ex_d.rd2  = rd2_d;
    id_ex_d.imm  = imm_d;
    id_ex_d.rs1  = if_id_q.instr[19:15];
    id_ex_d.rs2  = if_id_q.instr[24:20];
    id_ex_d.rd   = if_id_q.instr[11:7];
  end

  rv_stage_reg #(
    .payload_t(rv_pkg::id_ex_t),
    .bubble   ('0)
  ) u_id_ex (
    .clk  (clk),
    .rst_n(rst_n),
    .stall(1'b0),
    .flush(flush_e),
    .d    (id_ex_d),
    .q    (id_ex_q)
  );

  rv_hazard_unit u_hazard (
    .rs1_e      (id_ex_q.rs1),
    .rs2_e      (id_ex_q.rs2),
    .rd_e       (id_ex_q.rd),
    .rs1_d      (id_ex_d.rs1),
    .rs2_d      (id_ex_d.rs2),
    .rd_m       (ex_mem_q.rd),
    .rd_w       (mem_wb_q.rd),
    .mem_read_e (id_ex_q.ctrl.mem_read),
    .reg_write_m(ex_mem_q.ctrl.reg_write),
    .reg_write_w(mem_wb_q.reg_write),
    .take_branch(take_branch),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .stall_fd   (stall_fd),
    .flush_d    (flush_d),
    .flush_e    (flush_e)
  );

  // Execute
  rv_execute u_execute (
    .ex           (id_ex_q),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .result_m     (result_m),
    .result_w     (mem_wb_q.result),
    .alu_result   (alu_result_e),
    .store_data   (store_data_e),
    .take_branch  (take_branch),
    .branch_target(branch_target)
  );

  always_comb begin
    ex_mem_d.ctrl       = id_ex_q.ctrl;
    ex_mem_d.alu_result = alu_result_e;
    ex_mem_d.store_data = store_data_e;
    ex_mem_d.pc_plus_4  = id_ex_q.pc + 32'd4;
    ex_mem_d.rd         = id_ex_q.rd;
  end

  rv_stage_reg #(
    .payload_t(rv_pkg::ex_mem_t),
    .bubble   ('0)
  ) u_ex_mem (
    .clk  (clk),
    .rst_n(rst_n),
    .stall(1'b0),
    .flush(1'b0),
    .d    (ex_mem_d),
    .q    (ex_mem_q)
  );

  // Memory
  assign data_addr = ex_mem_q.alu_result;

  rv_lsu u_lsu (
    .mem         (ex_mem_q),
    .data_wdata  (data_wdata),
    .data_wenable(data_wenable),
    .data_rdata  (data_rdata),
    .load_data   (load_data_m)
  );

  // Also the memory-stage forward value, loads included
  always_comb begin
    case (ex_mem_q.ctrl.result_src)
      rv_pkg::res_mem:       result_m = load_data_m;
      rv_pkg::res_pc_plus_4: result_m = ex_mem_q.pc_plus_4;
      default:               result_m = ex_mem_q.alu_result;
    endcase
  end

  assign mem_wb_d = '{reg_write: ex_mem_q.ctrl.reg_write, rd: ex_mem_q.rd, result: result_m};

  // Writeback happens through the register file ports
  rv_stage_reg #(
    .payload_t(rv_pkg::mem_wb_t),
    .bubble   ('0)
  ) u_mem_wb (
    .clk  (clk),
    .rst_n(rst_n),
    .stall(1'b0),
    .flush(1'b0),
    .d    (mem_wb_d),
    .q    (mem_wb_q)
  );

endmodule

`default_nettype wire

// File: design/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // addi x0, x0, 0
  localparam word_t nop_instr = 32'h0000_0013;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  typedef enum logic {src_a_rs1, src_a_pc} alu_src_a_t;
  typedef enum logic {src_b_rs2, src_b_imm} alu_src_b_t;
  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_kind_t;
  typedef enum logic [1:0] {res_alu, res_mem, res_pc_plus_4} result_src_t;
  typedef enum logic [1:0] {br_none, br_cond, br_jal, br_jalr} branch_kind_t;
  typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_t;

  // Encoding follows funct3[1:0] of loads and stores
  typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_t;

  typedef struct packed {
    logic         reg_write;
    logic         mem_read;
    logic         mem_write;
    mem_size_t    mem_size;
    logic         mem_unsigned;
    result_src_t  result_src;
    alu_op_t      alu_op;
    alu_src_a_t   alu_src_a;
    alu_src_b_t   alu_src_b;
    branch_kind_t branch_kind;
    logic [2:0]   funct3;
  } ctrl_t;

  typedef struct packed {
    word_t instr;
    word_t pc;
  } if_id_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     pc;
    word_t     rd1;
    word_t     rd2;
    word_t     imm;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
  } id_ex_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     alu_result;
    word_t     store_data;
    word_t     pc_plus_4;
    reg_addr_t rd;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    reg_addr_t rd;
    word_t     result;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire rv_pkg::reg_addr_t ra1,
  input  wire rv_pkg::reg_addr_t ra2,
  output rv_pkg::word_t          rd1,
  output rv_pkg::word_t          rd2,
  input  wire                    we,
  input  wire rv_pkg::reg_addr_t wa,
  input  wire rv_pkg::word_t     wd
);

  rv_pkg::word_t regs [32];
  logic          write_live;

  // x0 is never written, so it stays at its reset value
  assign write_live = we && (wa != 5'd0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_live) begin
      regs[wa] <= wd;
    end
  end

  // Same-cycle writeback bypass
  assign rd1 = (write_live && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (write_live && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// File: design/rv_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_stage_reg #(
  parameter type payload_t = logic,
  parameter payload_t bubble = '0
) (
  input  wire      clk,
  input  wire      rst_n,
  input  wire      stall,
  input  wire      flush,
  input  wire      payload_t d,
  output payload_t q
);

  // Flush wins over stall
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      q <= bubble;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
  parameter int words = 256
) (
  input  wire                clk,
  input  wire rv_pkg::word_t rom_image [words],
  input  wire rv_pkg::word_t instr_addr,
  output rv_pkg::word_t      instr_data,
  input  wire rv_pkg::word_t data_addr,
  input  wire rv_pkg::word_t data_wdata,
  input  wire [3:0]          data_wenable,
  output rv_pkg::word_t      data_rdata
);

  localparam int aw = $clog2(words);

  rv_pkg::word_t ram [words];

  // Each word starts with its own index in the low half
  initial begin
    for (int i = 0; i < words; i++) begin
      ram[i] <= 32'hA5A5_0000 | i;
    end
  end

  assign instr_data = rom_image[instr_addr[aw+1:2]];

  // Reads are combinational, writes land on the rising edge
  assign data_rdata = ram[data_addr[aw+1:2]];

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (data_wenable[b]) begin
        ram[data_addr[aw+1:2]][8*b +: 8] <= data_wdata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_rv_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_pipeline;

  localparam int rom_words = 256;

  typedef struct packed {
    rv_pkg::word_t addr;
    rv_pkg::word_t data;
    logic [3:0]    enable;
  } store_t;

  logic          clk = 1'b0;
  logic          rst_n;
  rv_pkg::word_t instr_addr;
  rv_pkg::word_t instr_data;
  rv_pkg::word_t data_addr;
  rv_pkg::word_t data_wdata;
  logic [3:0]    data_wenable;
  rv_pkg::word_t data_rdata;
  rv_pkg::word_t rom_image [rom_words];

  rv_pkg::word_t program_q [$];
  store_t        expected_q [$];
  store_t        want;
  int            store_idx;
  int            value_errors;
  int            other_errors;
  logic [31:0]   lcg_state;

  always #4 clk = ~clk;

  rv_pipeline_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_addr  (instr_addr),
    .instr_data  (instr_data),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_wenable(data_wenable),
    .data_rdata  (data_rdata)
  );

  tb_mem_model #(
    .words(rom_words)
  ) u_mem (
    .clk         (clk),
    .rom_image   (rom_image),
    .instr_addr  (instr_addr),
    .instr_data  (instr_data),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_wenable(data_wenable),
    .data_rdata  (data_rdata)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [11:0] random_imm();
    logic [31:0] r;
    r = next_random();
    return r[27:16];
  endfunction

  function automatic rv_pkg::word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // RV32I instruction formats
  function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
      input rv_pkg::reg_addr_t rd, input rv_pkg::reg_addr_t rs1,
      input rv_pkg::reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
  endfunction

  function automatic rv_pkg::word_t i_type(input logic [6:0] op, input logic [2:0] f3,
      input rv_pkg::reg_addr_t rd, input rv_pkg::reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t s_type(input logic [2:0] f3,
      input rv_pkg::reg_addr_t rs1, input rv_pkg::reg_addr_t rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::op_store};
  endfunction

  function automatic rv_pkg::word_t b_type(input logic [2:0] f3,
      input rv_pkg::reg_addr_t rs1, input rv_pkg::reg_addr_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
  endfunction

  function automatic rv_pkg::word_t u_type(input logic [6:0] op,
      input rv_pkg::reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic rv_pkg::word_t j_type(input rv_pkg::reg_addr_t rd,
      input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal};
  endfunction

  function automatic rv_pkg::word_t current_pc();
    return rv_pkg::word_t'(program_q.size() * 4);
  endfunction

  task automatic emit(input rv_pkg::word_t instr);
    program_q.push_back(instr);
  endtask

  // Store relative to the data base in x31 and record what the bus should show
  task automatic store_expect(input logic [2:0] f3, input rv_pkg::reg_addr_t rs2,
      input logic [11:0] off, input rv_pkg::word_t data, input logic [3:0] enable);
    store_t entry;
    entry.addr   = 32'h100 + {20'b0, off};
    entry.data   = data;
    entry.enable = enable;
    emit(s_type(f3, 5'd31, rs2, off));
    expected_q.push_back(entry);
  endtask

  task automatic load_and_store(input logic [2:0] f3, input rv_pkg::reg_addr_t rd,
      input logic [11:0] load_off, input logic [11:0] save_off, input rv_pkg::word_t value);
    emit(i_type(rv_pkg::op_load, f3, rd, 5'd31, load_off));
    store_expect(3'b010, rd, save_off, value, 4'b1111);
  endtask

  task automatic build_program();
    logic [11:0]   a;
    logic [11:0]   b;
    rv_pkg::word_t va;
    rv_pkg::word_t vb;
    rv_pkg::word_t here;
    a  = random_imm();
    b  = random_imm();
    va = sext12(a);
    vb = sext12(b);
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd31, 5'd0, 12'h100));

    // Dependent chains through both forward paths and a dropped x0 write
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd1, 5'd0, a));
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd2, 5'd1, b));
    emit(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    emit(r_type(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd0, 5'd4, 12'd5));
    emit(r_type(7'h00, 3'b000, 5'd5, 5'd0, 5'd4));
    emit(r_type(7'h20, 3'b000, 5'd6, 5'd0, 5'd5));
    store_expect(3'b010, 5'd1, 12'd0, va, 4'b1111);
    store_expect(3'b010, 5'd2, 12'd4, va + vb, 4'b1111);
    store_expect(3'b010, 5'd3, 12'd8, va + va + vb, 4'b1111);
    store_expect(3'b010, 5'd4, 12'd12, va + vb, 4'b1111);
    store_expect(3'b010, 5'd5, 12'd16, va + vb, 4'b1111);
    store_expect(3'b010, 5'd6, 12'd20, 32'd0 - (va + vb), 4'b1111);
    store_expect(3'b010, 5'd0, 12'd24, 32'd0, 4'b1111);

    // Load then immediate use
    load_and_store(3'b010, 5'd7, 12'd0, 12'd28, va);
    emit(i_type(rv_pkg::op_load, 3'b010, 5'd8, 5'd31, 12'd4));
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd9, 5'd8, 12'd1));
    store_expect(3'b010, 5'd9, 12'd32, va + vb + 32'd1, 4'b1111);

    // Branches; stores at offset 200 and up sit in skipped slots
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd10, 5'd0, 12'd5));
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd12, 5'd0, 12'hFFD));
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd11, 5'd0, 12'd5));
    emit(b_type(3'b000, 5'd10, 5'd11, 13'd12));
    emit(s_type(3'b010, 5'd31, 5'd10, 12'd200));
    emit(s_type(3'b010, 5'd31, 5'd10, 12'd204));
    emit(b_type(3'b001, 5'd10, 5'd11, 13'd8));
    store_expect(3'b010, 5'd12, 12'd36, 32'hFFFF_FFFD, 4'b1111);
    emit(b_type(3'b100, 5'd12, 5'd10, 13'd8));
    emit(s_type(3'b010, 5'd31, 5'd10, 12'd208));
    emit(b_type(3'b111, 5'd12, 5'd10, 13'd8));
    emit(s_type(3'b010, 5'd31, 5'd10, 12'd212));
    emit(b_type(3'b000, 5'd10, 5'd12, 13'd8));
    store_expect(3'b010, 5'd11, 12'd40, 32'd5, 4'b1111);
    emit(b_type(3'b111, 5'd10, 5'd12, 13'd8));
    store_expect(3'b010, 5'd10, 12'd44, 32'd5, 4'b1111);
    emit(b_type(3'b100, 5'd10, 5'd12, 13'd8));
    store_expect(3'b010, 5'd12, 12'd48, 32'hFFFF_FFFD, 4'b1111);
    emit(b_type(3'b001, 5'd10, 5'd12, 13'd8));
    emit(s_type(3'b010, 5'd31, 5'd10, 12'd228));

    // JAL and JALR with links
    here = current_pc();
    emit(j_type(5'd14, 21'd12));
    emit(s_type(3'b010, 5'd31, 5'd10, 12'd216));
    emit(s_type(3'b010, 5'd31, 5'd10, 12'd220));
    store_expect(3'b010, 5'd14, 12'd52, here + 32'd4, 4'b1111);
    here = current_pc();
    emit(u_type(rv_pkg::op_auipc, 5'd15, 20'd0));
    // Odd offset so the target lands on here + 12
    emit(i_type(rv_pkg::op_jalr, 3'b000, 5'd16, 5'd15, 12'd13));
    emit(s_type(3'b010, 5'd31, 5'd10, 12'd224));
    store_expect(3'b010, 5'd16, 12'd56, here + 32'd8, 4'b1111);
    store_expect(3'b010, 5'd15, 12'd60, here, 4'b1111);

    // LUI and AUIPC
    emit(u_type(rv_pkg::op_lui, 5'd18, 20'hDEADB));
    store_expect(3'b010, 5'd18, 12'd64, 32'hDEAD_B000, 4'b1111);
    here = current_pc();
    emit(u_type(rv_pkg::op_auipc, 5'd19, 20'h12345));
    store_expect(3'b010, 5'd19, 12'd68, here + 32'h1234_5000, 4'b1111);
    emit(u_type(rv_pkg::op_lui, 5'd17, 20'h89ABC));
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd17, 5'd17, 12'h7EF));
    store_expect(3'b010, 5'd17, 12'd72, 32'h89AB_C7EF, 4'b1111);

    // Byte and half stores at every lane
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd20, 5'd0, 12'hF81));
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd21, 5'd0, 12'h07F));
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd22, 5'd0, 12'h0C3));
    emit(i_type(rv_pkg::op_imm, 3'b000, 5'd23, 5'd0, 12'h015));
    store_expect(3'b000, 5'd20, 12'd128, 32'h8181_8181, 4'b0001);
    store_expect(3'b000, 5'd21, 12'd129, 32'h7F7F_7F7F, 4'b0010);
    store_expect(3'b000, 5'd22, 12'd130, 32'hC3C3_C3C3, 4'b0100);
    store_expect(3'b000, 5'd23, 12'd131, 32'h1515_1515, 4'b1000);
    store_expect(3'b001, 5'd17, 12'd132, 32'hC7EF_C7EF, 4'b0011);
    store_expect(3'b001, 5'd18, 12'd134, 32'hB000_B000, 4'b1100);

    // Loads back with sign and zero extension
    load_and_store(3'b000, 5'd24, 12'd128, 12'd136, 32'hFFFF_FF81);
    load_and_store(3'b100, 5'd25, 12'd129, 12'd140, 32'h0000_007F);
    load_and_store(3'b000, 5'd26, 12'd130, 12'd144, 32'hFFFF_FFC3);
    load_and_store(3'b100, 5'd27, 12'd130, 12'd148, 32'h0000_00C3);
    load_and_store(3'b000, 5'd28, 12'd131, 12'd152, 32'h0000_0015);
    load_and_store(3'b001, 5'd29, 12'd132, 12'd156, 32'hFFFF_C7EF);
    load_and_store(3'b101, 5'd30, 12'd134, 12'd160, 32'h0000_B000);
    load_and_store(3'b001, 5'd7, 12'd134, 12'd164, 32'hFFFF_B000);
    load_and_store(3'b101, 5'd8, 12'd132, 12'd168, 32'h0000_C7EF);
    load_and_store(3'b010, 5'd9, 12'd128, 12'd172, 32'h15C3_7F81);
    load_and_store(3'b010, 5'd13, 12'd132, 12'd176, 32'hB000_C7EF);

    emit(j_type(5'd0, 21'd0));
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t expected,
      input rv_pkg::word_t actual);
    if (actual !== expected) begin
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_enable(input string name, input logic [3:0] expected,
      input logic [3:0] actual);
    if (actual !== expected) begin
      $display("ERR %s: expected %b, actual %b", name, expected, actual);
      value_errors++;
    end
  endtask

  // Self-jump refetches itself every third cycle behind its two successors
  task automatic check_closing_loop(input rv_pkg::word_t loop_pc);
    while (instr_addr !== loop_pc) begin
      @(negedge clk);
    end
    for (int k = 1; k <= 6; k++) begin
      @(negedge clk);
      check_word($sformatf("fetch %0d of closing loop", k),
                 loop_pc + 32'(4 * (k % 3)), instr_addr);
    end
  endtask

  task automatic report_and_finish();
    $display("Checks complete: %0d value errors, %0d other errors",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // Store monitor for at most one store per cycle
  always @(negedge clk) begin
    if (data_wenable != 4'b0000) begin
      if (store_idx < expected_q.size()) begin
        want = expected_q[store_idx];
        check_word($sformatf("store %0d address", store_idx), want.addr, data_addr);
        check_word($sformatf("store %0d data", store_idx), want.data, data_wdata);
        check_enable($sformatf("store %0d enables", store_idx), want.enable, data_wenable);
      end else begin
        $display("Store to address %h beyond the end of the expected list", data_addr);
        other_errors++;
      end
      store_idx++;
    end
  end

  initial begin
    rst_n        = 1'b0;
    store_idx    = 0;
    value_errors = 0;
    other_errors = 0;
    lcg_state    = 32'd42;
    build_program();
    for (int i = 0; i < rom_words; i++) begin
      if (i < program_q.size()) begin
        rom_image[i] = program_q[i];
      end else begin
        rom_image[i] = i_type(rv_pkg::op_imm, 3'b000, 5'd0, 5'd0, i[11:0]);
      end
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    while (store_idx < expected_q.size()) begin
      @(negedge clk);
    end
    check_closing_loop(rv_pkg::word_t'((program_q.size() - 1) * 4));
    report_and_finish();
  end

  initial begin
    int limit;
    @(posedge rst_n);
    limit = 20 * program_q.size() + 100;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d expected stores seen",
             limit, store_idx, expected_q.size());
    other_errors++;
    report_and_finish();
  end

endmodule

`default_nettype wire
